// ==== flist.f ====
hw/branchPkg.sv
hw/branchResolve.sv
hw/resolveQueue.sv
hw/bhtUpdater.sv
hw/branchUnitTop.sv
testbench/branchUnit_sva.sv
testbench/branchUnitTb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f flist.f --top-module branchUnitTb -o simv
	./obj_dir/simv | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/branchUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchUnitTb;
    import branchPkg::*;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic        exValid;
        logic        pValid;
        logic        pHit;
        logic [1:0]  pCount;
        branchKind_e pKind;
        logic [31:0] pTarget;
        logic        expFailed;
        logic [31:0] expVector;
        branchKind_e expKind;
        logic [1:0]  expCount;
    } stimRow_t;

    logic        clk;
    logic        rstN;
    logic        exValid;
    instrWord_u  exInstr;
    logic [31:0] exPc;
    logic [31:0] exOutA;
    logic [31:0] exOutB;
    pResult_t    exPResult;
    logic        lookupEn;
    logic [31:0] lookupPc;
    logic        predictionFailed;
    logic [31:0] correctionVector;
    bhtEntry_t   lookupEntry;
    logic        updatePending;
    logic        queueOverflow;

    stimRow_t    rows[$];
    logic [15:0] lfsrState;
    int          errors;
    int          checks;

    branchUnitTop #(
        .QUEUE_DEPTH (4),
        .INDEX_BITS  (4)
    ) u_branchUnitTop (
        .clk              (clk),
        .rstN             (rstN),
        .exValid          (exValid),
        .exInstr          (exInstr),
        .exPc             (exPc),
        .exOutA           (exOutA),
        .exOutB           (exOutB),
        .exPResult        (exPResult),
        .lookupEn         (lookupEn),
        .lookupPc         (lookupPc),
        .predictionFailed (predictionFailed),
        .correctionVector (correctionVector),
        .lookupEntry      (lookupEntry),
        .updatePending    (updatePending),
        .queueOverflow    (queueOverflow)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] iInstr(input logic [5:0] op, input logic [4:0] rt,
                                           input logic [15:0] imm);
        return {op, 5'd0, rt, imm};
    endfunction

    function automatic logic [31:0] jInstr(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    function automatic stimRow_t makeRow(
        input logic [31:0] instr, input logic [31:0] pc, input logic [31:0] a,
        input logic [31:0] b, input logic exV, input logic pV, input logic hit,
        input logic [1:0] cnt, input branchKind_e pKind, input logic [31:0] pTarget,
        input logic expFailed, input logic [31:0] expVector, input branchKind_e expKind,
        input logic [1:0] expCount
    );
        stimRow_t r;
        r = {instr, pc, a, b, exV, pV, hit, cnt, pKind, pTarget,
             expFailed, expVector, expKind, expCount};
        return r;
    endfunction

    function automatic bhtEntry_t makeEntry(input logic [1:0] cnt, input branchKind_e kind,
                                            input logic [31:0] target);
        bhtEntry_t e;
        e.valid  = 1'b1;
        e.count  = cnt;
        e.kind   = kind;
        e.target = target;
        return e;
    endfunction

    // fibonacci lfsr with taps 16 14 13 11, one step per bit
    function automatic logic [31:0] getBits(input int n);
        logic [31:0] result;
        logic        fb;
        result = '0;
        for (int i = 0; i < n; i++) begin
            fb        = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], fb};
            result    = {result[30:0], fb};
        end
        return result;
    endfunction

    // reference for BEQ (0), BNE (1) and BLTZ (2)
    function automatic logic [31:0] refTarget(input int code, input logic [31:0] pc,
                                              input logic [15:0] imm, input logic [31:0] a,
                                              input logic [31:0] b);
        logic        taken;
        logic [31:0] offs;
        case (code)
            0:       taken = (a == b);
            1:       taken = (a != b);
            default: taken = a[31]; // negative operand
        endcase
        offs = {{14{imm[15]}}, imm, 2'b00};
        return taken ? (pc + 32'd4 + offs) : (pc + 32'd8);
    endfunction

    task automatic checkValue(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic driveBranch(input logic [31:0] instr, input logic [31:0] pc,
                               input logic [31:0] a, input logic [31:0] b, input logic exV,
                               input logic pV, input logic hit, input logic [1:0] cnt,
                               input branchKind_e kind, input logic [31:0] target);
        exValid          = exV;
        exInstr          = instr;
        exPc             = pc;
        exOutA           = a;
        exOutB           = b;
        exPResult.valid  = pV;
        exPResult.hit    = hit;
        exPResult.count  = cnt;
        exPResult.kind   = kind;
        exPResult.target = target;
    endtask

    task automatic waitDrain(input string phase);
        int cycles;
        cycles = 0;
        while (updatePending && cycles < 50) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (updatePending) begin
            $display("timeout: queue still not empty after 50 cycles in %s", phase);
            $display("errors %0d of %0d checks", errors, checks);
            $display("test failed");
            $finish;
        end
    endtask

    task automatic lookupCheck(input string name, input logic [31:0] pc, input bhtEntry_t exp);
        @(posedge clk);
        #1 lookupEn = 1'b1;
        lookupPc = pc;
        @(posedge clk);
        #1 lookupEn = 1'b0;
        checkValue(name, {27'd0, exp}, {27'd0, lookupEntry});
    endtask

    task automatic buildTable;
        rows.push_back(makeRow(iInstr(OP_SPECIAL, 5'd0, 16'h0020), 32'h1000, 32'd1, 32'd2,
                               1, 1, 1, 2'd2, NONE, 32'h1008, 0, 32'h1008, NONE, 2'd1));
        rows.push_back(makeRow(iInstr(OP_BEQ, 5'd0, 16'h0004), 32'h1000, 32'd1, 32'd1,
                               1, 0, 0, 2'd0, IMME, 32'h0, 0, 32'h1014, IMME, 2'd0));
        rows.push_back(makeRow(iInstr(OP_BNE, 5'd0, 16'h0004), 32'h1000, 32'd1, 32'd1,
                               0, 1, 0, 2'd0, IMME, 32'h0, 0, 32'h1008, IMME, 2'd0));
        rows.push_back(makeRow(iInstr(OP_BEQ, 5'd0, 16'h0004), 32'h1000, 32'd5, 32'd5,
                               1, 1, 1, 2'd1, IMME, 32'h1014, 0, 32'h1014, IMME, 2'd2));
        rows.push_back(makeRow(iInstr(OP_BEQ, 5'd0, 16'h0004), 32'h1004, 32'd5, 32'd6,
                               1, 1, 0, 2'd0, IMME, 32'h1018, 1, 32'h100C, IMME, 2'd1));
        rows.push_back(makeRow(iInstr(OP_BNE, 5'd0, 16'hFFFE), 32'h1008, 32'd1, 32'd2,
                               1, 1, 1, 2'd3, IMME, 32'h1004, 0, 32'h1004, IMME, 2'd3));
        rows.push_back(makeRow(iInstr(OP_BNE, 5'd0, 16'h0008), 32'h100C, 32'd7, 32'd7,
                               1, 1, 1, 2'd0, IMME, 32'h1014, 0, 32'h1014, IMME, 2'd0));
        rows.push_back(makeRow(iInstr(OP_REGIMM, RT_BGEZ, 16'h0003), 32'h1010, 32'd0, 32'd0,
                               1, 1, 0, 2'd0, IMME, 32'h0, 1, 32'h1020, IMME, 2'd2));
        rows.push_back(makeRow(iInstr(OP_REGIMM, RT_BGEZ, 16'h0003), 32'h1014, 32'h80000000,
                               32'd0, 1, 1, 1, 2'd2, IMME, 32'h101C, 0, 32'h101C, IMME, 2'd1));
        rows.push_back(makeRow(iInstr(OP_BGTZ, 5'd0, 16'h0002), 32'h1018, 32'd1, 32'd0,
                               1, 1, 1, 2'd2, IMME, 32'h1024, 0, 32'h1024, IMME, 2'd3));
        rows.push_back(makeRow(iInstr(OP_BGTZ, 5'd0, 16'h0002), 32'h101C, 32'd0, 32'd0,
                               1, 1, 1, 2'd2, IMME, 32'h1024, 0, 32'h1024, IMME, 2'd1));
        rows.push_back(makeRow(iInstr(OP_BLEZ, 5'd0, 16'h0001), 32'h1020, 32'd0, 32'd0,
                               1, 1, 1, 2'd2, IMME, 32'h1028, 0, 32'h1028, IMME, 2'd3));
        rows.push_back(makeRow(iInstr(OP_BLEZ, 5'd0, 16'h0001), 32'h1024, 32'd5, 32'd0,
                               1, 1, 1, 2'd2, IMME, 32'h1030, 1, 32'h102C, IMME, 2'd1));
        rows.push_back(makeRow(iInstr(OP_REGIMM, RT_BLTZ, 16'h0010), 32'h1028, 32'hFFFFFFFF,
                               32'd0, 1, 1, 1, 2'd2, IMME, 32'h106C, 0, 32'h106C, IMME, 2'd3));
        rows.push_back(makeRow(iInstr(OP_REGIMM, RT_BLTZ, 16'h0010), 32'h102C, 32'd1, 32'd0,
                               1, 1, 1, 2'd2, IMME, 32'h1034, 0, 32'h1034, IMME, 2'd1));
        rows.push_back(makeRow(jInstr(OP_J, 26'h0000400), 32'h1030, 32'd0, 32'd0,
                               1, 1, 1, 2'd2, IMME, 32'h1000, 0, 32'h1000, IMME, 2'd3));
        rows.push_back(makeRow(jInstr(OP_JAL, 26'h0000500), 32'h1034, 32'd0, 32'd0,
                               1, 1, 1, 2'd3, CALL, 32'h1400, 0, 32'h1400, CALL, 2'd3));
        rows.push_back(makeRow(iInstr(OP_SPECIAL, 5'd0, 16'h0008), 32'h1038, 32'h2000, 32'd0,
                               1, 1, 0, 2'd0, RETN, 32'h2000, 0, 32'h2000, RETN, 2'd2));
        rows.push_back(makeRow(iInstr(OP_SPECIAL, 5'd0, 16'h0009), 32'h103C, 32'h3000, 32'd0,
                               1, 1, 1, 2'd0, CALL, 32'h3004, 1, 32'h3000, CALL, 2'd1));
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [31:0] expVec;
        logic [15:0] imm;
        logic [31:0] instr;
        logic [31:0] pTarget;
        int          code;
        stimRow_t    r;

        errors    = 0;
        checks    = 0;
        lfsrState = 16'd48150;
        rstN      = 1'b0;
        lookupEn  = 1'b0;
        lookupPc  = '0;
        driveBranch('0, '0, '0, '0, 0, 0, 0, 2'd0, NONE, '0);
        repeat (5) @(posedge clk);
        #1 rstN = 1'b1;
        checkValue("reset updatePending", 64'd0, {63'd0, updatePending});
        checkValue("reset queueOverflow", 64'd0, {63'd0, queueOverflow});
        checkValue("reset lookupEntry", 64'd0, {27'd0, lookupEntry});

        // directed table
        buildTable();
        foreach (rows[i]) begin
            r = rows[i];
            @(posedge clk);
            #1 driveBranch(r.instr, r.pc, r.a, r.b, r.exValid, r.pValid, r.pHit, r.pCount,
                           r.pKind, r.pTarget);
            #4;
            checkValue($sformatf("row %0d predictionFailed", i), {63'd0, r.expFailed},
                       {63'd0, predictionFailed});
            checkValue($sformatf("row %0d correctionVector", i), {32'd0, r.expVector},
                       {32'd0, correctionVector});
        end
        @(posedge clk);
        #1 exValid = 1'b0;
        waitDrain("directed phase");

        // table contents for the branches that were pushed
        foreach (rows[i]) begin
            r = rows[i];
            if (r.exValid && r.pValid && r.expKind != NONE) begin
                lookupCheck($sformatf("row %0d lookupEntry", i), r.pc,
                            makeEntry(r.expCount, r.expKind, r.expVector));
            end
        end

        // random BEQ BNE and BLTZ at table index 0
        for (int n = 0; n < 24; n++) begin
            code = int'(getBits(2)) % 3;
            a    = getBits(32);
            b    = getBits(1) ? a : getBits(32);
            imm  = 16'(getBits(16));
            pc   = 32'h4000 + (getBits(8) << 6);
            case (code)
                0:       instr = iInstr(OP_BEQ, 5'd0, imm);
                1:       instr = iInstr(OP_BNE, 5'd0, imm);
                default: instr = iInstr(OP_REGIMM, RT_BLTZ, imm);
            endcase
            expVec  = refTarget(code, pc, imm, a, b);
            pTarget = getBits(1) ? expVec : (expVec ^ 32'h10);
            @(posedge clk);
            #1 driveBranch(instr, pc, a, b, 1, 1, 1, 2'd1, IMME, pTarget);
            #4;
            checkValue($sformatf("random %0d predictionFailed", n),
                       {63'd0, pTarget != expVec}, {63'd0, predictionFailed});
            checkValue($sformatf("random %0d correctionVector", n), {32'd0, expVec},
                       {32'd0, correctionVector});
        end
        @(posedge clk);
        #1 exValid = 1'b0;
        waitDrain("random phase");

        // held lookup blocks updates so the fifth push overflows
        @(posedge clk);
        #1 lookupEn = 1'b1;
        lookupPc = 32'h0;
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            if (i == 4) begin
                #1 checkValue("overflow before fifth push", 64'd0, {63'd0, queueOverflow});
            end else begin
                #1;
            end
            driveBranch(iInstr(OP_SPECIAL, 5'd0, 16'h0008), 32'h5004 + 32'(4 * i),
                        32'h7000 + 32'(16 * i), 32'd0, 1, 1, 0, 2'd0, RETN,
                        32'h7000 + 32'(16 * i));
        end
        @(posedge clk);
        #1 exValid = 1'b0;
        checkValue("overflow after fifth push", 64'd1, {63'd0, queueOverflow});
        checkValue("pending while lookup held", 64'd1, {63'd0, updatePending});
        lookupEn = 1'b0;
        waitDrain("overflow phase");
        for (int i = 0; i < 4; i++) begin
            lookupCheck($sformatf("held record %0d", i), 32'h5004 + 32'(4 * i),
                        makeEntry(2'd2, RETN, 32'h7000 + 32'(16 * i)));
        end
        lookupCheck("dropped record slot", 32'h5014, makeEntry(2'd1, IMME, 32'h101C));

        $display("errors %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/branchUnit_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchUnitSva (
    input logic clk,
    input logic rstN,
    input logic exValid,
    input logic exPValid,
    input logic predictionFailed,
    input logic updatePending,
    input logic lookupEn,
    input logic pop
);

    // a failure needs a live instruction with a prediction
    property failNeedsValid;
        @(posedge clk) disable iff (!rstN)
            predictionFailed |-> (exValid && exPValid);
    endproperty

    property emptyAfterReset;
        @(posedge clk) !rstN |=> !updatePending;
    endproperty

    property lookupOwnsPort; // no table write under a lookup
        @(posedge clk) disable iff (!rstN)
            lookupEn |-> !pop;
    endproperty

    assert property (failNeedsValid) else $error("predictionFailed without valid input");
    assert property (emptyAfterReset) else $error("updatePending high after reset");
    assert property (lookupOwnsPort) else $error("pop while lookupEn high");

endmodule

bind branchUnitTop branchUnitSva u_branchUnitSva (
    .clk              (clk),
    .rstN             (rstN),
    .exValid          (exValid),
    .exPValid         (exPResult.valid),
    .predictionFailed (predictionFailed),
    .updatePending    (updatePending),
    .lookupEn         (lookupEn),
    .pop              (pop)
);

`default_nettype wire

// ==== hw/branchUnitTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchUnitTop #(
    parameter int QUEUE_DEPTH = 4,
    parameter int INDEX_BITS  = 4
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  exValid,
    input  branchPkg::instrWord_u exInstr,
    input  logic [31:0]           exPc,
    input  logic [31:0]           exOutA,
    input  logic [31:0]           exOutB,
    input  branchPkg::pResult_t   exPResult,
    input  logic                  lookupEn,
    input  logic [31:0]           lookupPc,
    output logic                  predictionFailed,
    output logic [31:0]           correctionVector,
    output branchPkg::bhtEntry_t  lookupEntry,
    output logic                  updatePending,
    output logic                  queueOverflow
);
    import branchPkg::*;

    bResult_t resolveResult;
    bResult_t headRecord;
    logic     notEmpty;
    logic     pop;

    branchResolve u_branchResolve (
        .exValid          (exValid),
        .exInstr          (exInstr),
        .exPc             (exPc),
        .exOutA           (exOutA),
        .exOutB           (exOutB),
        .exPResult        (exPResult),
        .predictionFailed (predictionFailed),
        .correctionVector (correctionVector),
        .resolveResult    (resolveResult)
    );

    resolveQueue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_resolveQueue (
        .clk        (clk),
        .rstN       (rstN),
        .pushRecord (resolveResult), // pushes whenever valid, no handshake
        .pop        (pop),
        .headRecord (headRecord),
        .notEmpty   (notEmpty),
        .overflow   (queueOverflow)
    );

    bhtUpdater #(
        .INDEX_BITS (INDEX_BITS)
    ) u_bhtUpdater (
        .clk         (clk),
        .rstN        (rstN),
        .headRecord  (headRecord),
        .notEmpty    (notEmpty),
        .lookupEn    (lookupEn),
        .lookupPc    (lookupPc),
        .pop         (pop),
        .lookupEntry (lookupEntry)
    );

    // drained queue means every record is in the table
    assign updatePending = notEmpty;

endmodule

`default_nettype wire

// ==== hw/bhtUpdater.sv ====
`timescale 1ns/1ps
`default_nettype none

module bhtUpdater #(
    parameter int INDEX_BITS = 4
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  branchPkg::bResult_t  headRecord,
    input  logic                 notEmpty,
    input  logic                 lookupEn,
    input  logic [31:0]          lookupPc,
    output logic                 pop,
    output branchPkg::bhtEntry_t lookupEntry
);
    import branchPkg::*;

    localparam int ENTRIES = 1 << INDEX_BITS;

    bhtEntry_t             entryMem [ENTRIES];
    logic [ENTRIES-1:0]    validBits;
    logic [INDEX_BITS-1:0] wrIndex;
    logic [INDEX_BITS-1:0] rdIndex;
    logic                  wrEn;
    bhtEntry_t             writeEntry;

    // two-bit counter, saturating on a hit, reseeded on a miss
    function automatic logic [1:0] nextCount(
        input logic       hit,
        input logic       taken,
        input logic [1:0] count
    );
        logic [1:0] result;
        if (hit) begin
            if (taken) begin
                result = (count == 2'd3) ? 2'd3 : count + 2'd1;
            end else begin
                result = (count == 2'd0) ? 2'd0 : count - 2'd1;
            end
        end else begin
            result = taken ? 2'd2 : 2'd1; // weakly taken or weakly not
        end
        return result;
    endfunction

    // word-aligned PC, so index starts at bit 2
    assign wrIndex = headRecord.pc[INDEX_BITS+1:2];
    assign rdIndex = lookupPc[INDEX_BITS+1:2];

    // lookup owns the port whenever it asks
    assign pop  = notEmpty && !lookupEn;
    assign wrEn = pop && headRecord.valid;

    always_comb begin
        writeEntry.valid  = 1'b1;
        writeEntry.count  = nextCount(headRecord.hit, headRecord.isTaken, headRecord.count);
        writeEntry.kind   = headRecord.kind;
        writeEntry.target = headRecord.target;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validBits   <= '0;
            lookupEntry <= '0;
        end else begin
            if (lookupEn) begin
                lookupEntry <= validBits[rdIndex] ? entryMem[rdIndex] : '0;
            end
            if (wrEn) validBits[wrIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) entryMem[wrIndex] <= writeEntry;
    end

endmodule

`default_nettype wire

// ==== hw/resolveQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module resolveQueue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rstN,
    input  branchPkg::bResult_t pushRecord,
    input  logic                pop,
    output branchPkg::bResult_t headRecord,
    output logic                notEmpty,
    output logic                overflow
);
    import branchPkg::*;

    localparam int PTR_BITS = $clog2(QUEUE_DEPTH);

    bResult_t            slots [QUEUE_DEPTH];
    logic [PTR_BITS-1:0] wrPtr;
    logic [PTR_BITS-1:0] rdPtr;
    logic [PTR_BITS:0]   count;     // one extra bit to tell full from empty
    logic                full;
    logic                doPop;
    logic                doPush;

    assign full     = (count == (PTR_BITS + 1)'(QUEUE_DEPTH));
    assign notEmpty = (count != '0);
    assign doPop    = pop && notEmpty;
    assign doPush   = pushRecord.valid && (!full || doPop); // same-cycle pop frees a slot

    assign headRecord = slots[rdPtr];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (doPush) wrPtr <= wrPtr + 1'b1; // wraps, depth is a power of two
            if (doPop) rdPtr <= rdPtr + 1'b1;
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            if (pushRecord.valid && !doPush) overflow <= 1'b1; // sticky
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) slots[wrPtr] <= pushRecord;
    end

endmodule

`default_nettype wire

// ==== hw/branchResolve.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchResolve (
    input  logic                  exValid,
    input  branchPkg::instrWord_u exInstr,
    input  logic [31:0]           exPc,
    input  logic [31:0]           exOutA,
    input  logic [31:0]           exOutB,
    input  branchPkg::pResult_t   exPResult,
    output logic                  predictionFailed,
    output logic [31:0]           correctionVector,
    output branchPkg::bResult_t   resolveResult
);
    import branchPkg::*;

    branchType_t brType;
    logic        isCall;        // JAL or JALR
    logic [31:0] pcPlus4;
    logic [31:0] pc8;           // return point past the delay slot
    logic [31:0] branchAddr;
    logic [31:0] jumpAddr;

    logic        opEqual;
    logic        aIsZero;
    logic        aIsNeg;

    logic        isTaken;
    branchKind_e actualKind;
    logic [31:0] actualTarget;
    logic        predSuccess;

    // decode class from opcode, rt and funct
    always_comb begin
        brType.isBranch = 1'b0;
        brType.code     = BEQ;
        isCall          = 1'b0;
        case (exInstr.iType.opcode)
            OP_BEQ:  {brType.isBranch, brType.code} = {1'b1, BEQ};
            OP_BNE:  {brType.isBranch, brType.code} = {1'b1, BNE};
            OP_BLEZ: {brType.isBranch, brType.code} = {1'b1, BLEZ};
            OP_BGTZ: {brType.isBranch, brType.code} = {1'b1, BGTZ};
            OP_J:    {brType.isBranch, brType.code} = {1'b1, J};
            OP_JAL: begin
                {brType.isBranch, brType.code} = {1'b1, J};
                isCall                         = 1'b1;
            end
            OP_REGIMM: begin
                if (exInstr.iType.rt == RT_BLTZ) begin
                    {brType.isBranch, brType.code} = {1'b1, BLTZ};
                end else if (exInstr.iType.rt == RT_BGEZ) begin
                    {brType.isBranch, brType.code} = {1'b1, BGEZ};
                end
            end
            OP_SPECIAL: begin
                if (exInstr.iType.imm[5:0] == FN_JR) begin
                    {brType.isBranch, brType.code} = {1'b1, JR};
                end else if (exInstr.iType.imm[5:0] == FN_JALR) begin
                    {brType.isBranch, brType.code} = {1'b1, JR};
                    isCall                         = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign pcPlus4    = exPc + 32'd4;
    assign pc8        = exPc + 32'd8;
    assign branchAddr = pcPlus4 + {{14{exInstr.iType.imm[15]}}, exInstr.iType.imm, 2'b00};
    assign jumpAddr   = {pcPlus4[31:28], exInstr.jType.index, 2'b00};

    assign opEqual = (exOutA == exOutB);
    assign aIsZero = (exOutA == 32'd0);
    assign aIsNeg  = exOutA[31];

    // actual direction
    always_comb begin
        if (brType.isBranch) begin
            unique case (brType.code)
                BEQ:     isTaken = opEqual;
                BNE:     isTaken = !opEqual;
                BGEZ:    isTaken = !aIsNeg;
                BGTZ:    isTaken = !aIsNeg && !aIsZero;
                BLEZ:    isTaken = aIsNeg || aIsZero;
                BLTZ:    isTaken = aIsNeg;
                default: isTaken = 1'b1; // J and JR always go
            endcase
        end else begin
            isTaken = 1'b0;
        end
    end

    // actual target and kind
    always_comb begin
        if (brType.isBranch) begin
            unique case (brType.code)
                J: begin
                    actualKind   = isCall ? CALL : IMME;
                    actualTarget = jumpAddr;
                end
                JR: begin
                    actualKind   = isCall ? CALL : RETN;
                    actualTarget = exOutA;
                end
                default: begin
                    actualKind   = IMME;
                    actualTarget = isTaken ? branchAddr : pc8;
                end
            endcase
        end else begin
            actualKind   = NONE;
            actualTarget = pc8;
        end
    end

    // every class succeeds on a matching target
    assign predSuccess = (exPResult.target == actualTarget);

    assign predictionFailed = !predSuccess && exPResult.valid && exValid;
    assign correctionVector = actualTarget;

    always_comb begin
        resolveResult.valid       = exValid && exPResult.valid;
        resolveResult.pc          = exPc;
        resolveResult.kind        = actualKind;
        resolveResult.isTaken     = isTaken;
        resolveResult.target      = actualTarget;
        resolveResult.count       = exPResult.count;
        resolveResult.hit         = exPResult.hit;
        resolveResult.retnSuccess = predSuccess && (exPResult.kind == RETN) && exValid;
    end

endmodule

`default_nettype wire

// ==== hw/branchPkg.sv ====
`default_nettype none

package branchPkg;

    // primary opcode field
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;

    localparam logic [5:0] FN_JR      = 6'h08; // funct codes under SPECIAL
    localparam logic [5:0] FN_JALR    = 6'h09;

    localparam logic [4:0] RT_BLTZ    = 5'h00; // rt selects the REGIMM compare
    localparam logic [4:0] RT_BGEZ    = 5'h01;

    typedef enum logic [2:0] {
        BEQ,
        BNE,
        BGEZ,
        BGTZ,
        BLEZ,
        BLTZ,
        J,
        JR
    } branchCode_e;

    typedef enum logic [1:0] {
        NONE,
        IMME,
        CALL,
        RETN
    } branchKind_e;

    typedef struct packed {
        logic        isBranch;
        branchCode_e code;
    } branchType_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iType_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;
    } jType_t;

    // same 32 bits, read as either layout
    typedef union packed {
        iType_t iType;
        jType_t jType;
    } instrWord_u;

    // prediction carried down the pipe with the instruction
    typedef struct packed {
        logic        valid;
        logic        hit;
        logic [1:0]  count;
        branchKind_e kind;
        logic [31:0] target;
    } pResult_t;

    // correction record sent back to the table
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        branchKind_e kind;
        logic        isTaken;
        logic [31:0] target;
        logic [1:0]  count;
        logic        hit;
        logic        retnSuccess;
    } bResult_t;

    typedef struct packed {
        logic        valid;
        logic [1:0]  count;
        branchKind_e kind;
        logic [31:0] target;
    } bhtEntry_t;

endpackage

`default_nettype wire
